// File: source/qc_pkg.sv
package qc_pkg;

  localparam int num_queues = 4;
  localparam int prio_w = 2;
  localparam int addr_w = 10;
  localparam int ram_depth = 1024;
  localparam int fifo_depth = 16;
  localparam int fifo_aw = $clog2(fifo_depth);
  localparam int count_w = 6;

  typedef struct packed {
    logic last;  // end of frame
    logic [prio_w-1:0] prio;
    logic [addr_w-1:0] addr;  // buffer slot
  } cell_t;

  typedef enum logic [1:0] {
    deq_idle,
    deq_read,
    deq_send
  } deq_state_e;

  typedef enum logic [7:0] {
    reg_enable = 8'h00,
    reg_count0 = 8'h10,
    reg_count1 = 8'h14,
    reg_count2 = 8'h18,
    reg_count3 = 8'h1C
  } reg_addr_e;

endpackage

// File: source/cell_fifo.sv
`timescale 1ns/10ps

module cell_fifo (
  input  logic           clk,
  input  logic           rst,
  input  qc_pkg::cell_t  cell_in,
  input  logic           cell_in_valid,
  output logic           cell_in_ready,
  output qc_pkg::cell_t  enq_cell,
  output logic           enq_valid
);

  qc_pkg::cell_t mem [qc_pkg::fifo_depth];
  logic [qc_pkg::fifo_aw-1:0] wr_ptr;
  logic [qc_pkg::fifo_aw-1:0] rd_ptr;
  logic [qc_pkg::fifo_aw:0] used;
  logic push;

  assign cell_in_ready = ~used[qc_pkg::fifo_aw];  // msb set only when full
  assign push = cell_in_valid & cell_in_ready;
  assign enq_valid = (used != '0);  // link store never stalls
  assign enq_cell = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cell_in;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (enq_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, enq_valid})
        2'b10: used <= used + 1'b1;
        2'b01: used <= used - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: source/link_store.sv
`timescale 1ns/10ps

module link_store (
  input  logic                                             clk,
  input  logic                                             rst,
  input  qc_pkg::cell_t                                    enq_cell,
  input  logic                                             enq_valid,
  input  logic [qc_pkg::addr_w-1:0]                        rd_addr,
  input  logic                                             pop_valid,
  input  logic [qc_pkg::prio_w-1:0]                        pop_queue,
  input  logic                                             pop_last,
  input  logic [qc_pkg::addr_w-1:0]                        pop_next,
  output qc_pkg::cell_t                                    rd_next,
  output logic [qc_pkg::num_queues-1:0][qc_pkg::addr_w-1:0] head,
  output logic [qc_pkg::num_queues-1:0][qc_pkg::count_w-1:0] frame_count
);

  logic [qc_pkg::addr_w-1:0] next_ram [qc_pkg::ram_depth];
  logic [qc_pkg::prio_w:0] flag_ram [qc_pkg::ram_depth];  // last and prio of each slot
  logic [qc_pkg::num_queues-1:0][qc_pkg::addr_w-1:0] tail;
  logic [qc_pkg::num_queues-1:0] empty_q;
  logic [qc_pkg::num_queues-1:0] enq_hit;
  logic [qc_pkg::num_queues-1:0] pop_hit;
  logic ram_we;
  logic [qc_pkg::addr_w-1:0] ram_waddr;

  always_comb begin
    for (int q = 0; q < qc_pkg::num_queues; q++) begin
      enq_hit[q] = enq_valid && (enq_cell.prio == q[qc_pkg::prio_w-1:0]);
      pop_hit[q] = pop_valid && (pop_queue == q[qc_pkg::prio_w-1:0]);
    end
  end

  // link the new cell behind the old tail
  assign ram_we = enq_valid && !empty_q[enq_cell.prio];
  assign ram_waddr = tail[enq_cell.prio];

  // rd_next holds the flags of the cell at rd_addr and the address of its successor
  always_ff @(posedge clk) begin
    if (ram_we) begin
      next_ram[ram_waddr] <= enq_cell.addr;
    end
    if (enq_valid) begin
      flag_ram[enq_cell.addr] <= {enq_cell.last, enq_cell.prio};
    end
    if (ram_we && ram_waddr == rd_addr) begin
      rd_next.addr <= enq_cell.addr;  // write-first
    end else begin
      rd_next.addr <= next_ram[rd_addr];
    end
    {rd_next.last, rd_next.prio} <= flag_ram[rd_addr];
  end

  always_ff @(posedge clk) begin
    for (int q = 0; q < qc_pkg::num_queues; q++) begin
      if (enq_hit[q]) begin
        tail[q] <= enq_cell.addr;
        if (empty_q[q]) begin
          head[q] <= enq_cell.addr;
        end
      end
      if (pop_hit[q]) begin
        if (head[q] != tail[q]) begin
          head[q] <= pop_next;
        end else if (enq_hit[q]) begin
          head[q] <= enq_cell.addr;  // list drained and refilled at once
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      empty_q <= '1;
      frame_count <= '0;
    end else begin
      for (int q = 0; q < qc_pkg::num_queues; q++) begin
        if (enq_hit[q]) begin
          empty_q[q] <= 1'b0;
        end else if (pop_hit[q] && head[q] == tail[q]) begin
          empty_q[q] <= 1'b1;  // popped the only cell
        end
        case ({enq_hit[q] & enq_cell.last, pop_hit[q] & pop_last})
          2'b10: frame_count[q] <= frame_count[q] + 1'b1;
          2'b01: frame_count[q] <= frame_count[q] - 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: source/frame_dequeue.sv
`timescale 1ns/10ps

module frame_dequeue (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [qc_pkg::num_queues-1:0]                     queue_enable,
  input  logic [qc_pkg::num_queues-1:0][qc_pkg::count_w-1:0] frame_count,
  input  logic [qc_pkg::num_queues-1:0][qc_pkg::addr_w-1:0]  head,
  input  qc_pkg::cell_t                                     rd_next,
  input  logic                                              cell_out_ready,
  output logic [qc_pkg::addr_w-1:0]                         rd_addr,
  output logic                                              pop_valid,
  output logic [qc_pkg::prio_w-1:0]                         pop_queue,
  output logic                                              pop_last,
  output logic [qc_pkg::addr_w-1:0]                         pop_next,
  output qc_pkg::cell_t                                     cell_out,
  output logic                                              cell_out_valid
);

  qc_pkg::deq_state_e state;
  logic [qc_pkg::prio_w-1:0] cur_q;
  logic [qc_pkg::addr_w-1:0] cur_addr;
  logic [qc_pkg::prio_w-1:0] sel_q;
  logic found;

  // strict priority with the highest index winning
  always_comb begin
    found = 1'b0;
    sel_q = '0;
    for (int q = 0; q < qc_pkg::num_queues; q++) begin
      if (queue_enable[q] && frame_count[q] != '0) begin
        found = 1'b1;
        sel_q = q[qc_pkg::prio_w-1:0];
      end
    end
  end

  assign rd_addr = cur_addr;  // held through send so stalls keep the read fresh
  assign cell_out_valid = (state == qc_pkg::deq_send);
  assign pop_valid = cell_out_valid & cell_out_ready;
  assign pop_queue = cur_q;
  assign pop_last = rd_next.last;
  assign pop_next = rd_next.addr;

  always_comb begin
    cell_out.last = rd_next.last;
    cell_out.prio = rd_next.prio;
    cell_out.addr = cur_addr;
  end

  always_ff @(posedge clk) begin
    if (state == qc_pkg::deq_idle && found) begin
      cur_q <= sel_q;  // locked until end of frame
      cur_addr <= head[sel_q];
    end else if (pop_valid && !rd_next.last) begin
      cur_addr <= rd_next.addr;  // follow the list
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= qc_pkg::deq_idle;
    end else begin
      case (state)
        qc_pkg::deq_idle: begin
          if (found) begin
            state <= qc_pkg::deq_read;
          end
        end
        qc_pkg::deq_read: state <= qc_pkg::deq_send;
        qc_pkg::deq_send: begin
          if (pop_valid) begin
            state <= rd_next.last ? qc_pkg::deq_idle : qc_pkg::deq_read;
          end
        end
        default: state <= qc_pkg::deq_idle;
      endcase
    end
  end

endmodule

// File: source/queue_regs.sv
`timescale 1ns/10ps

module queue_regs (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [7:0]                                        paddr,
  input  logic                                              psel,
  input  logic                                              penable,
  input  logic                                              pwrite,
  input  logic [31:0]                                       pwdata,
  input  logic [qc_pkg::num_queues-1:0][qc_pkg::count_w-1:0] frame_count,
  output logic [31:0]                                       prdata,
  output logic                                              pready,
  output logic                                              pslverr,
  output logic [qc_pkg::num_queues-1:0]                     queue_enable
);

  logic access;
  logic mapped;
  logic is_enable;

  assign access = psel & penable;
  assign pready = 1'b1;  // zero wait states
  assign is_enable = (paddr == qc_pkg::reg_enable);
  assign pslverr = access & (!mapped | (pwrite & !is_enable));  // counts are read only

  always_comb begin
    prdata = '0;
    mapped = 1'b1;
    case (paddr)
      qc_pkg::reg_enable: prdata[qc_pkg::num_queues-1:0] = queue_enable;
      qc_pkg::reg_count0: prdata[qc_pkg::count_w-1:0] = frame_count[0];
      qc_pkg::reg_count1: prdata[qc_pkg::count_w-1:0] = frame_count[1];
      qc_pkg::reg_count2: prdata[qc_pkg::count_w-1:0] = frame_count[2];
      qc_pkg::reg_count3: prdata[qc_pkg::count_w-1:0] = frame_count[3];
      default: mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      queue_enable <= '1;  // all queues served
    end else if (access && pwrite && is_enable) begin
      queue_enable <= pwdata[qc_pkg::num_queues-1:0];
    end
  end

endmodule

// File: source/queue_ctrl_top.sv
`timescale 1ns/10ps

module queue_ctrl_top (
  input  logic           clk,
  input  logic           rst,
  input  qc_pkg::cell_t  cell_in,
  input  logic           cell_in_valid,
  output logic           cell_in_ready,
  output qc_pkg::cell_t  cell_out,
  output logic           cell_out_valid,
  input  logic           cell_out_ready,
  input  logic [7:0]     paddr,
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  logic [31:0]    pwdata,
  output logic [31:0]    prdata,
  output logic           pready,
  output logic           pslverr
);

  qc_pkg::cell_t enq_cell;
  logic enq_valid;
  qc_pkg::cell_t rd_next;
  logic [qc_pkg::addr_w-1:0] rd_addr;
  logic pop_valid;
  logic [qc_pkg::prio_w-1:0] pop_queue;
  logic pop_last;
  logic [qc_pkg::addr_w-1:0] pop_next;
  logic [qc_pkg::num_queues-1:0][qc_pkg::addr_w-1:0] head;
  logic [qc_pkg::num_queues-1:0][qc_pkg::count_w-1:0] frame_count;
  logic [qc_pkg::num_queues-1:0] queue_enable;

  cell_fifo cell_fifo_inst (
    .clk(clk), .rst(rst), .cell_in(cell_in), .cell_in_valid(cell_in_valid),
    .cell_in_ready(cell_in_ready), .enq_cell(enq_cell), .enq_valid(enq_valid)
  );

  link_store link_store_inst (
    .clk(clk), .rst(rst), .enq_cell(enq_cell), .enq_valid(enq_valid), .rd_addr(rd_addr),
    .pop_valid(pop_valid), .pop_queue(pop_queue), .pop_last(pop_last), .pop_next(pop_next),
    .rd_next(rd_next), .head(head), .frame_count(frame_count)
  );

  frame_dequeue frame_dequeue_inst (
    .clk(clk), .rst(rst), .queue_enable(queue_enable), .frame_count(frame_count),
    .head(head), .rd_next(rd_next), .cell_out_ready(cell_out_ready), .rd_addr(rd_addr),
    .pop_valid(pop_valid), .pop_queue(pop_queue), .pop_last(pop_last),
    .pop_next(pop_next), .cell_out(cell_out), .cell_out_valid(cell_out_valid)
  );

  queue_regs queue_regs_inst (
    .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .frame_count(frame_count), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .queue_enable(queue_enable)
  );

endmodule

// File: verification/queue_ctrl_scoreboard.sv
`timescale 1ns/10ps

module queue_ctrl_scoreboard (
  input  logic           clk,
  input  qc_pkg::cell_t  cell_out,
  input  logic           cell_out_valid,
  input  logic           cell_out_ready
);

  qc_pkg::cell_t exp_q [$];
  qc_pkg::cell_t exp_c;
  int errors = 0;
  int test_errors = 0;
  int tests = 0;

  task automatic expect_cell(input qc_pkg::cell_t c);
    exp_q.push_back(c);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("error %s exp 0x%0h got 0x%0h", name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  // sampled at the edge before the DUT registers move
  always @(posedge clk) begin
    if (cell_out_valid && cell_out_ready) begin
      if (exp_q.size() == 0) begin
        $display("cell 0x%0h left the output while no cell was expected", cell_out);
        errors++;
        test_errors++;
      end else begin
        exp_c = exp_q.pop_front();
        check_value("cell_out", 32'(exp_c), 32'(cell_out));
      end
    end
  end

  task automatic finish_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report();
    $display("tests run %0d, errors %0d", tests, errors);
  endtask

endmodule

// File: verification/queue_ctrl_checker.sv
`timescale 1ns/10ps

module queue_ctrl_checker (
  input  logic                      clk,
  input  logic                      rst,
  input  qc_pkg::cell_t             cell_out,
  input  logic                      cell_out_valid,
  input  logic                      cell_out_ready,
  input  logic                      cell_in_ready,
  input  logic                      pop_valid,
  input  logic [qc_pkg::prio_w-1:0] pop_queue
);

  int fails = 0;

  hold_while_stalled: assert property (@(posedge clk) disable iff (!rst)
    cell_out_valid && !cell_out_ready |=> cell_out_valid && $stable(cell_out))
    else begin
      fails++;
      $error("cell_out changed while stalled");
    end

  pop_needs_valid: assert property (@(posedge clk) disable iff (!rst)
    pop_valid |-> cell_out_valid && pop_queue == cell_out.prio)
    else begin
      fails++;
      $error("pop without cell_out_valid or from a queue other than the cell's own");
    end

  ready_after_reset: assert property (@(posedge clk) $rose(rst) |-> cell_in_ready)
    else begin
      fails++;
      $error("cell_in_ready low after reset");
    end

endmodule

bind queue_ctrl_top queue_ctrl_checker queue_ctrl_checker_inst (.*);

// File: verification/queue_ctrl_tb.sv
`timescale 1ns/10ps

module queue_ctrl_tb;

  localparam int tbl_n = 17;

  logic clk;
  logic rst;
  qc_pkg::cell_t cell_in;
  logic cell_in_valid;
  logic cell_in_ready;
  qc_pkg::cell_t cell_out;
  logic cell_out_valid;
  logic cell_out_ready;
  logic [7:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic stall_on;
  logic [31:0] rd;
  logic err;

  // one row per frame with test number, priority, length and first buffer slot
  int tbl_test [tbl_n] = '{2, 3, 3, 3, 3, 3, 3, 4, 4, 4, 4, 5, 5, 5, 5, 5, 5};
  int tbl_prio [tbl_n] = '{1, 0, 2, 1, 2, 3, 0, 3, 1, 3, 0, 1, 3, 0, 2, 3, 1};
  int tbl_len [tbl_n] = '{4, 3, 2, 1, 3, 2, 1, 2, 3, 1, 2, 8, 6, 5, 7, 4, 5};
  int tbl_start [tbl_n] = '{'h010, 'h020, 'h030, 'h040, 'h050, 'h060, 'h070, 'h080,
                            'h090, 'h0a0, 'h0b0, 'h100, 'h110, 'h120, 'h130, 'h140, 'h150};

  queue_ctrl_top queue_ctrl_top_inst (
    .clk(clk), .rst(rst), .cell_in(cell_in), .cell_in_valid(cell_in_valid),
    .cell_in_ready(cell_in_ready), .cell_out(cell_out), .cell_out_valid(cell_out_valid),
    .cell_out_ready(cell_out_ready), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  queue_ctrl_scoreboard sb (
    .clk(clk), .cell_out(cell_out), .cell_out_valid(cell_out_valid),
    .cell_out_ready(cell_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // output back-pressure is random only while stall_on is set
  initial begin
    logic stall_now;
    void'($urandom(32'hf4866c47));
    cell_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      stall_now = stall_on;
      #1;
      cell_out_ready <= stall_now ? ($urandom_range(0, 2) != 0) : 1'b1;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int n;
    n = 0;
    paddr = addr;
    pwrite = wr;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1 penable = 1'b1;
    do begin
      @(posedge clk);
      n++;
    end while (!pready && n < 20);
    if (!pready) abort_run("apb access never saw pready");
    rdata = prdata;
    slverr = pslverr;
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] dummy;
    logic slverr;
    apb_access(1'b1, addr, wdata, dummy, slverr);
    sb.check_value("pslverr", 32'h0, {31'h0, slverr});
  endtask

  function automatic qc_pkg::cell_t make_cell(input int e, input int i);
    qc_pkg::cell_t c;
    c.last = (i == tbl_len[e] - 1);
    c.prio = 2'(tbl_prio[e]);
    c.addr = 10'(tbl_start[e] + i);
    return c;
  endfunction

  task automatic send_frames(input int t);
    int n;
    for (int e = 0; e < tbl_n; e++) begin
      if (tbl_test[e] == t) begin
        for (int i = 0; i < tbl_len[e]; i++) begin
          cell_in = make_cell(e, i);
          cell_in_valid = 1'b1;
          n = 0;
          do begin
            @(posedge clk);
            n++;
          end while (!cell_in_ready && n < 50);
          if (!cell_in_ready) abort_run("input stream stuck with cell_in_ready low");
          #1;
        end
      end
    end
    cell_in_valid = 1'b0;
  endtask

  // descending priority then table order within a priority
  task automatic expect_frames(input int t, input logic [3:0] mask);
    for (int p = qc_pkg::num_queues - 1; p >= 0; p--) begin
      for (int e = 0; e < tbl_n; e++) begin
        if (mask[p] && tbl_test[e] == t && tbl_prio[e] == p) begin
          for (int i = 0; i < tbl_len[e]; i++) begin
            sb.expect_cell(make_cell(e, i));
          end
        end
      end
    end
  endtask

  task automatic check_counts(input int t, input logic [3:0] mask);
    int exp;
    repeat (2) @(posedge clk);  // let the last cell reach the lists
    #1;
    for (int q = 0; q < qc_pkg::num_queues; q++) begin
      exp = 0;
      for (int e = 0; e < tbl_n; e++) begin
        if (mask[q] && tbl_test[e] == t && tbl_prio[e] == q) exp++;
      end
      apb_access(1'b0, 8'(8'h10 + 4 * q), 32'h0, rd, err);
      sb.check_value($sformatf("frame_count%0d", q), 32'(exp), rd);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (sb.pending() != 0 && n < 3000) begin
      @(posedge clk);
      n++;
    end
    if (sb.pending() != 0) abort_run("expected cells never left the output stream");
    @(posedge clk);
    #1;
  endtask

  initial begin
    rst = 1'b0;
    cell_in = '0;
    cell_in_valid = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    stall_on = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b1;
    @(posedge clk);
    #1;

    apb_access(1'b0, 8'h00, 32'h0, rd, err);
    sb.check_value("queue_enable", 32'hf, rd);
    check_counts(0, 4'hf);
    sb.finish_test("reset state");

    expect_frames(2, 4'hf);
    send_frames(2);
    wait_drain();
    sb.finish_test("single frame");

    apb_write(8'h00, 32'h0);
    send_frames(3);
    check_counts(3, 4'hf);
    expect_frames(3, 4'hf);
    apb_write(8'h00, 32'hf);
    wait_drain();
    sb.finish_test("strict priority");

    apb_write(8'h00, 32'h0);
    send_frames(4);
    expect_frames(4, 4'h7);
    apb_write(8'h00, 32'h7);
    wait_drain();
    check_counts(4, 4'h8);  // queue 3 still held back
    expect_frames(4, 4'h8);
    apb_write(8'h00, 32'hf);
    wait_drain();
    sb.finish_test("masked queue");

    apb_write(8'h00, 32'h0);
    send_frames(5);
    check_counts(5, 4'hf);
    expect_frames(5, 4'hf);
    stall_on = 1'b1;
    apb_write(8'h00, 32'hf);
    wait_drain();
    stall_on = 1'b0;
    sb.finish_test("random stalls");

    apb_access(1'b0, 8'h04, 32'h0, rd, err);
    sb.check_value("pslverr", 32'h1, {31'h0, err});
    apb_access(1'b1, 8'h10, 32'h5, rd, err);
    sb.check_value("pslverr", 32'h1, {31'h0, err});
    apb_access(1'b0, 8'h10, 32'h0, rd, err);
    sb.check_value("frame_count0", 32'h0, rd);
    sb.finish_test("bad access");

    sb.report();
    if (sb.errors == 0 && queue_ctrl_top_inst.queue_ctrl_checker_inst.fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
source/qc_pkg.sv
source/cell_fifo.sv
source/link_store.sv
source/frame_dequeue.sv
source/queue_regs.sv
source/queue_ctrl_top.sv
verification/queue_ctrl_scoreboard.sv
verification/queue_ctrl_checker.sv
verification/queue_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the queue controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module queue_ctrl_tb \
  -o sim_model > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_model > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && echo "simulation failed" && exit 1
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
